/* logic/procPkg.sv */
// shared widths, opcode encodings and the packed bundles of the processor
// every block refers to these by scoped name, e.g. procPkg::ctrlT
package procPkg;

   localparam int wordWidth    = 16;  // data and address width
   localparam int regAddrWidth = 3;   // eight registers
   localparam int memDepth     = 256; // words per memory
   localparam int memAddrWidth = 8;   // word index into either memory

   localparam logic [regAddrWidth-1:0] linkReg = 3'd7; // JAL target register

   // R-format function field, bits 1..0
   localparam logic [1:0] funcAdd = 2'b00;
   localparam logic [1:0] funcSub = 2'b01;
   localparam logic [1:0] funcXor = 2'b10;
   localparam logic [1:0] funcAnd = 2'b11; // plain AND in this subset

   // opcode bits 15..11, same encodings as the full teaching set
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opJal   = 5'b00110,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opLbi   = 5'b11000,
      opRType = 5'b11011  // add/sub/xor/and picked by func
   } opcodeE;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,   // a minus b
      aluAndn,  // a and not b
      aluAnd,
      aluXor,
      aluPassB
   } aluOpE;

   typedef enum logic [2:0] {
      wbSrcAlu,
      wbSrcMem,
      wbSrcPc2,  // link value
      wbSrcLbi,
      wbSrcSlbi
   } wbSrcE;

   // control bundle from decode
   typedef struct packed {
      aluOpE                   aluOp;
      logic                    aluBImm;      // b operand is imm
      logic                    regWe;
      logic [regAddrWidth-1:0] regDst;
      wbSrcE                   wbSrc;
      logic                    memRd;
      logic                    memWr;
      logic                    branch;
      logic                    branchOnZero; // beqz when set, bnez when clear
      logic                    jump;
      logic                    link;
      logic                    halt;         // also set for illegal opcodes
      logic                    illegal;
   } ctrlT;

   // one record per retired instruction
   typedef struct packed {
      logic                    valid;
      logic [wordWidth-1:0]    pc;
      logic                    regWe;
      logic [regAddrWidth-1:0] regDst;
      logic [wordWidth-1:0]    regData;
   } retireT;

endpackage

/* logic/fetch.sv */
// program counter and instruction memory
// imem is written through the program port only while rst is high,
// instr is read combinationally at pc
module fetch (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             imemWe,
   input  logic [procPkg::memAddrWidth-1:0] imemAddr,
   input  logic [procPkg::wordWidth-1:0]    imemData,
   input  logic [procPkg::wordWidth-1:0]    pcNext,
   input  logic                             stop,     // halt or illegal this cycle
   output logic [procPkg::wordWidth-1:0]    instr,
   output logic [procPkg::wordWidth-1:0]    pc,
   output logic [procPkg::wordWidth-1:0]    pcPlusTwo,
   output logic                             halted
);

   logic [procPkg::wordWidth-1:0] imem [procPkg::memDepth];

   // loader port, closed once rst drops
   always_ff @(posedge clk) begin
      if (rst && imemWe) begin
         imem[imemAddr] <= imemData;
      end
   end

   assign instr     = imem[pc[procPkg::memAddrWidth:1]]; // byte pc, word index
   assign pcPlusTwo = pc + procPkg::wordWidth'(2);

   // pc frozen once halted
   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (!halted) begin
         pc <= pcNext;
      end
   end

   // sticky stop flag, cleared by rst only
   always_ff @(posedge clk) begin
      if (rst) begin
         halted <= 1'b0;
      end else if (stop) begin
         halted <= 1'b1;
      end
   end

endmodule

/* logic/regFile.sv */
// eight-entry register file
// two combinational read ports, one write port on the clock edge
module regFile (
   input  logic                             clk,
   input  logic                             rst,
   input  logic [procPkg::regAddrWidth-1:0] rdAddr1,
   input  logic [procPkg::regAddrWidth-1:0] rdAddr2,
   input  logic                             wrEn,
   input  logic [procPkg::regAddrWidth-1:0] wrAddr,
   input  logic [procPkg::wordWidth-1:0]    wrData,
   output logic [procPkg::wordWidth-1:0]    rdData1,
   output logic [procPkg::wordWidth-1:0]    rdData2
);

   localparam int numRegs = 2 ** procPkg::regAddrWidth;

   logic [procPkg::wordWidth-1:0] regs [numRegs];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData; // r0 is a normal register
      end
   end

   // no bypass, a write shows up next cycle
   assign rdData1 = regs[rdAddr1];
   assign rdData2 = regs[rdAddr2];

endmodule

/* logic/decode.sv */
// instruction decode with the register file
// splits the fields, builds the immediate and the control bundle,
// flags unknown opcodes and latches err until rst
module decode (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [procPkg::wordWidth-1:0] instr,
   input  logic                          halted,
   input  logic [procPkg::wordWidth-1:0] wbData,
   output procPkg::ctrlT                 ctrl,
   output logic [procPkg::wordWidth-1:0] data1,
   output logic [procPkg::wordWidth-1:0] data2,
   output logic [procPkg::wordWidth-1:0] imm,
   output logic                          err
);

   procPkg::opcodeE                  opcode;
   logic [procPkg::regAddrWidth-1:0] rs, rt, rdR, rdI;
   logic [1:0]                       func;

   assign opcode = procPkg::opcodeE'(instr[15:11]);
   assign rs     = instr[10:8];
   assign rt     = instr[7:5];  // also the store source
   assign rdI    = instr[7:5];
   assign rdR    = instr[4:2];
   assign func   = instr[1:0];

   regFile regFileInst (
      .clk     (clk),
      .rst     (rst),
      .rdAddr1 (rs),
      .rdAddr2 (rt),
      .wrEn    (ctrl.regWe & ~halted), // nothing written after stop
      .wrAddr  (ctrl.regDst),
      .wrData  (wbData),
      .rdData1 (data1),
      .rdData2 (data2)
   );

   // one immediate per instruction
   always_comb begin
      case (opcode)
         procPkg::opAddi, procPkg::opSubi,
         procPkg::opLd, procPkg::opSt:  imm = {{(procPkg::wordWidth-5){instr[4]}}, instr[4:0]};
         procPkg::opAndni:              imm = {{(procPkg::wordWidth-5){1'b0}}, instr[4:0]};
         procPkg::opLbi, procPkg::opBeqz,
         procPkg::opBnez:               imm = {{(procPkg::wordWidth-8){instr[7]}}, instr[7:0]};
         procPkg::opSlbi:               imm = {data1[7:0], instr[7:0]}; // rs shifted, byte or'd in
         procPkg::opJ, procPkg::opJal:  imm = {{(procPkg::wordWidth-11){instr[10]}}, instr[10:0]};
         default:                       imm = '0;
      endcase
   end

   always_comb begin
      ctrl        = '0;
      ctrl.aluOp  = procPkg::aluAdd;
      ctrl.wbSrc  = procPkg::wbSrcAlu;
      ctrl.regDst = rdI;
      case (opcode)
         procPkg::opHalt: ctrl.halt = 1'b1;
         procPkg::opNop:  ;
         procPkg::opAddi, procPkg::opSubi, procPkg::opAndni: begin
            ctrl.aluBImm = 1'b1;
            ctrl.regWe   = 1'b1;
            if (opcode == procPkg::opSubi) ctrl.aluOp = procPkg::aluSub;   // rs - imm
            if (opcode == procPkg::opAndni) ctrl.aluOp = procPkg::aluAndn;
         end
         procPkg::opRType: begin
            ctrl.regWe  = 1'b1;
            ctrl.regDst = rdR;
            case (func)
               procPkg::funcAdd: ctrl.aluOp = procPkg::aluAdd;
               procPkg::funcSub: ctrl.aluOp = procPkg::aluSub;
               procPkg::funcXor: ctrl.aluOp = procPkg::aluXor;
               default:          ctrl.aluOp = procPkg::aluAnd;
            endcase
         end
         procPkg::opLbi, procPkg::opSlbi: begin
            ctrl.regWe   = 1'b1;
            ctrl.regDst  = rs; // writes back into rs
            ctrl.aluOp   = procPkg::aluPassB;
            ctrl.aluBImm = 1'b1;
            ctrl.wbSrc   = (opcode == procPkg::opLbi) ? procPkg::wbSrcLbi : procPkg::wbSrcSlbi;
         end
         procPkg::opLd: begin
            ctrl.aluBImm = 1'b1; // rs + imm is the address
            ctrl.memRd   = 1'b1;
            ctrl.regWe   = 1'b1;
            ctrl.wbSrc   = procPkg::wbSrcMem;
         end
         procPkg::opSt: begin
            ctrl.aluBImm = 1'b1;
            ctrl.memWr   = 1'b1;
         end
         procPkg::opBeqz: begin
            ctrl.branch       = 1'b1;
            ctrl.branchOnZero = 1'b1;
         end
         procPkg::opBnez: ctrl.branch = 1'b1;
         procPkg::opJ:    ctrl.jump   = 1'b1;
         procPkg::opJal: begin
            ctrl.jump  = 1'b1;
            ctrl.link  = 1'b1;
            ctrl.regWe = 1'b1;
            ctrl.wbSrc = procPkg::wbSrcPc2;
         end
         default: begin
            ctrl.illegal = 1'b1; // unknown opcode traps
            ctrl.halt    = 1'b1;
         end
      endcase
      if (ctrl.link) ctrl.regDst = procPkg::linkReg;
   end

   // err goes up on the same edge as halted
   always_ff @(posedge clk) begin
      if (rst) begin
         err <= 1'b0;
      end else if (ctrl.illegal) begin
         err <= 1'b1;
      end
   end

endmodule

/* logic/execute.sv */
// ALU, branch test and next-pc choice
// purely combinational, aluOut doubles as the data memory address
module execute (
   input  procPkg::ctrlT                 ctrl,
   input  logic [procPkg::wordWidth-1:0] pc,
   input  logic [procPkg::wordWidth-1:0] pcPlusTwo,
   input  logic [procPkg::wordWidth-1:0] data1,
   input  logic [procPkg::wordWidth-1:0] data2,
   input  logic [procPkg::wordWidth-1:0] imm,
   output logic [procPkg::wordWidth-1:0] aluOut,
   output logic [procPkg::wordWidth-1:0] pcNext
);

   logic [procPkg::wordWidth-1:0] aluB;
   logic [procPkg::wordWidth-1:0] target;
   logic                          isZero;
   logic                          taken;

   assign aluB = ctrl.aluBImm ? imm : data2;

   always_comb begin
      case (ctrl.aluOp)
         procPkg::aluAdd:   aluOut = data1 + aluB;
         procPkg::aluSub:   aluOut = data1 - aluB;
         procPkg::aluAndn:  aluOut = data1 & ~aluB;
         procPkg::aluAnd:   aluOut = data1 & aluB;
         procPkg::aluXor:   aluOut = data1 ^ aluB;
         procPkg::aluPassB: aluOut = aluB;
         default:           aluOut = '0;
      endcase
   end

   // branch and jump share one adder, displacement relative to pc+2
   assign target = pcPlusTwo + imm;

   assign isZero = (data1 == '0);
   assign taken  = ctrl.branch && (isZero == ctrl.branchOnZero);

   always_comb begin
      if (ctrl.halt) begin
         pcNext = pc;        // stay on the halt or illegal word
      end else if (ctrl.jump || taken) begin
         pcNext = target;
      end else begin
         pcNext = pcPlusTwo; // fall through
      end
   end

endmodule

/* logic/memory.sv */
// data memory, word addressed by addr bits 8..1
// read is combinational, store lands on the clock edge
module memory (
   input  logic                          clk,
   input  logic                          rst,
   input  procPkg::ctrlT                 ctrl,
   input  logic                          halted,
   input  logic [procPkg::wordWidth-1:0] addr,
   input  logic [procPkg::wordWidth-1:0] writeData,
   output logic [procPkg::wordWidth-1:0] readData
);

   logic [procPkg::wordWidth-1:0]    dmem [procPkg::memDepth];
   logic [procPkg::memAddrWidth-1:0] index;

   assign index = addr[procPkg::memAddrWidth:1]; // byte address, low bit dropped

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < procPkg::memDepth; i++) begin
            dmem[i] <= '0; // known contents for every run
         end
      end else if (ctrl.memWr && !halted) begin
         dmem[index] <= writeData;
      end
   end

   assign readData = ctrl.memRd ? dmem[index] : '0; // quiet unless LD

endmodule

/* logic/writeback.sv */
// picks the register write value and builds the retire record
module writeback (
   input  procPkg::ctrlT                 ctrl,
   input  logic [procPkg::wordWidth-1:0] pc,
   input  logic                          halted,
   input  logic [procPkg::wordWidth-1:0] aluOut,
   input  logic [procPkg::wordWidth-1:0] readData,
   input  logic [procPkg::wordWidth-1:0] pcPlusTwo,
   input  logic [procPkg::wordWidth-1:0] imm,
   output logic [procPkg::wordWidth-1:0] wbData,
   output procPkg::retireT               retire
);

   always_comb begin
      case (ctrl.wbSrc)
         procPkg::wbSrcMem:  wbData = readData;
         procPkg::wbSrcPc2:  wbData = pcPlusTwo;          // JAL link
         procPkg::wbSrcLbi,
         procPkg::wbSrcSlbi: wbData = imm;                // SLBI merged with rs in decode
         default:            wbData = aluOut;
      endcase
   end

   always_comb begin
      retire.valid   = ~halted; // one per cycle until stopped
      retire.pc      = pc;
      retire.regWe   = ctrl.regWe;
      retire.regDst  = ctrl.regDst;
      retire.regData = wbData;
   end

endmodule

/* logic/proc.sv */
// single-cycle processor top level
// program is loaded through imemWe/imemAddr/imemData while rst is high,
// one retire record per clock after that until halt
module proc (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             imemWe,
   input  logic [procPkg::memAddrWidth-1:0] imemAddr,
   input  logic [procPkg::wordWidth-1:0]    imemData,
   output procPkg::retireT                  retire,
   output logic                             halt,
   output logic                             err
);

   logic [procPkg::wordWidth-1:0] instr, pc, pcPlusTwo, pcNext;
   logic [procPkg::wordWidth-1:0] data1, data2, imm;
   logic [procPkg::wordWidth-1:0] aluOut, readData, wbData;
   procPkg::ctrlT                 ctrl;

   fetch fetchInst (
      .clk       (clk),
      .rst       (rst),
      .imemWe    (imemWe),
      .imemAddr  (imemAddr),
      .imemData  (imemData),
      .pcNext    (pcNext),
      .stop      (ctrl.halt), // halt or illegal
      .instr     (instr),
      .pc        (pc),
      .pcPlusTwo (pcPlusTwo),
      .halted    (halt)
   );

   decode decodeInst (
      .clk    (clk),
      .rst    (rst),
      .instr  (instr),
      .halted (halt),
      .wbData (wbData),
      .ctrl   (ctrl),
      .data1  (data1),
      .data2  (data2),
      .imm    (imm),
      .err    (err)
   );

   execute executeInst (
      .ctrl      (ctrl),
      .pc        (pc),
      .pcPlusTwo (pcPlusTwo),
      .data1     (data1),
      .data2     (data2),
      .imm       (imm),
      .aluOut    (aluOut),
      .pcNext    (pcNext)
   );

   memory memoryInst (
      .clk       (clk),
      .rst       (rst),
      .ctrl      (ctrl),
      .halted    (halt),
      .addr      (aluOut),
      .writeData (data2), // store source is rd field
      .readData  (readData)
   );

   writeback writebackInst (
      .ctrl      (ctrl),
      .pc        (pc),
      .halted    (halt),
      .aluOut    (aluOut),
      .readData  (readData),
      .pcPlusTwo (pcPlusTwo),
      .imm       (imm),
      .wbData    (wbData),
      .retire    (retire)
   );

endmodule

/* verification/proc_sva.sv */
// assertions on halt, err and the retire trace of proc
// bound into every proc instance from the testbench
module procSva (
   input logic            clk,
   input logic            rst,
   input logic            halt,
   input logic            err,
   input procPkg::retireT retire
);
   timeunit 1ns;
   timeprecision 100ps;

   // a stop is only undone by reset
   haltSticky: assert property (@(posedge clk) $fell(halt) |-> $past(rst))
      else $error("halt fell while rst was low");

   // nothing retires and pc holds on the stopping word once stopped
   retireQuiet: assert property (@(posedge clk) halt |-> !retire.valid && $stable(retire.pc))
      else $error("retire active or pc moving while halt is high");

   // illegal opcode always stops the machine
   errHalts: assert property (@(posedge clk) err |-> halt)
      else $error("err high without halt");

endmodule

/* verification/procTb.sv */
// testbench for proc, each test loads a short program during reset and runs it to halt
// every retire record is compared with a reference model of the instruction set
module procTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          timeoutCycles = 200;
   localparam int          resetCycles   = 4;
   localparam logic [15:0] haltWord      = 16'h0000; // HALT
   localparam logic [15:0] illegalWord   = 16'h1000; // opcode 00010, not in the set

   logic                             clk      = 1'b0;
   logic                             rst      = 1'b1;
   logic                             imemWe   = 1'b0;
   logic [procPkg::memAddrWidth-1:0] imemAddr = '0;
   logic [procPkg::wordWidth-1:0]    imemData = '0;
   procPkg::retireT                  retire;
   logic                             halt;
   logic                             err;

   logic [15:0] prog [procPkg::memDepth]; // program image, read by the model too
   int          progLen;
   logic [15:0] refRegs [8];              // model state
   logic [15:0] refMem [procPkg::memDepth];
   logic [15:0] refPc;
   logic        refStopped;
   logic        refIllegal;
   int          mismatches = 0;
   int          failures   = 0;            // timeouts, stop errors

   proc proc_inst (
      .clk      (clk),
      .rst      (rst),
      .imemWe   (imemWe),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .retire   (retire),
      .halt     (halt),
      .err      (err)
   );

   bind proc procSva procSvaInst (.*);

   always #4 clk = ~clk; // 8 ns period

   function automatic logic [15:0] rWord(logic [2:0] rs, rt, rd, logic [1:0] func);
      return {procPkg::opRType, rs, rt, rd, func};
   endfunction

   function automatic logic [15:0] iWord(logic [4:0] op, logic [2:0] rs, rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] bWord(logic [4:0] op, logic [2:0] rs, logic [7:0] imm);
      return {op, rs, imm}; // LBI, SLBI, BEQZ, BNEZ
   endfunction

   function automatic logic [15:0] jWord(logic [4:0] op, logic [10:0] disp);
      return {op, disp};
   endfunction

   task automatic emit(input logic [15:0] w);
      prog[progLen] = w;
      progLen++;
   endtask

   // LBI high byte then SLBI low byte gives the full word
   task automatic setConst(input logic [2:0] r, input logic [15:0] v);
      emit(bWord(procPkg::opLbi, r, v[15:8]));
      emit(bWord(procPkg::opSlbi, r, v[7:0]));
   endtask

   // rst high for at least 4 cycles, one program word per cycle
   task automatic resetAndLoad();
      int n;
      n = (progLen > resetCycles) ? progLen : resetCycles;
      @(posedge clk);
      #1;
      rst = 1'b1;
      for (int i = 0; i < n; i++) begin
         imemWe   = (i < progLen);
         imemAddr = 8'(i);
         imemData = prog[i];
         @(posedge clk);
         #1;
      end
      imemWe = 1'b0;
      rst    = 1'b0;
      for (int k = 0; k < 8; k++) begin
         refRegs[k] = '0;
      end
      for (int k = 0; k < procPkg::memDepth; k++) begin
         refMem[k] = '0; // data memory starts cleared
      end
      refPc      = '0;
      refStopped = 1'b0;
      refIllegal = 1'b0;
   endtask

   // executes one instruction from the encoding rules, returns the expected record
   task automatic modelStep(output procPkg::retireT exp);
      logic [15:0] w, a, b, s5, s8, addr, val, nextPc;
      logic [4:0]  op;
      logic [2:0]  dst;
      logic        we;
      w      = prog[refPc[8:1]];
      op     = w[15:11];
      a      = refRegs[w[10:8]]; // rs
      b      = refRegs[w[7:5]];  // rt, also store source
      s5     = {{11{w[4]}}, w[4:0]};
      s8     = {{8{w[7]}}, w[7:0]};
      addr   = a + s5;
      nextPc = refPc + 16'd2;
      val    = '0;
      case (op)
         procPkg::opAddi:  val = a + s5;
         procPkg::opSubi:  val = a - s5;
         procPkg::opAndni: val = a & ~{11'b0, w[4:0]}; // zero extended
         procPkg::opRType: begin
            case (w[1:0])
               procPkg::funcAdd: val = a + b;
               procPkg::funcSub: val = a - b;
               procPkg::funcXor: val = a ^ b;
               procPkg::funcAnd: val = a & b;
            endcase
         end
         procPkg::opLbi:   val = s8;
         procPkg::opSlbi:  val = (a << 8) | {8'h00, w[7:0]}; // rs up one byte
         procPkg::opLd:    val = refMem[addr[8:1]];
         procPkg::opSt:    refMem[addr[8:1]] = b;
         procPkg::opBeqz:  nextPc = (a == 16'd0) ? nextPc + s8 : nextPc;
         procPkg::opBnez:  nextPc = (a != 16'd0) ? nextPc + s8 : nextPc;
         procPkg::opJ:     nextPc = nextPc + {{5{w[10]}}, w[10:0]};
         procPkg::opJal: begin
            val    = nextPc; // link
            nextPc = nextPc + {{5{w[10]}}, w[10:0]};
         end
         procPkg::opHalt:  refStopped = 1'b1;
         procPkg::opNop:   ;
         default: begin
            refStopped = 1'b1;
            refIllegal = 1'b1;
         end
      endcase
      we  = op inside {procPkg::opAddi, procPkg::opSubi, procPkg::opAndni, procPkg::opRType,
                       procPkg::opLbi, procPkg::opSlbi, procPkg::opLd, procPkg::opJal};
      dst = w[7:5];
      if (op == procPkg::opRType) dst = w[4:2];
      if (op inside {procPkg::opLbi, procPkg::opSlbi}) dst = w[10:8];
      if (op == procPkg::opJal) dst = 3'd7;
      exp.valid   = 1'b1;
      exp.pc      = refPc;
      exp.regWe   = we;
      exp.regDst  = dst;
      exp.regData = val;
      if (we) refRegs[dst] = val;
      if (!refStopped) refPc = nextPc;
   endtask

   // destination and data only matter when a register is written
   task automatic checkRetire(input string name, input procPkg::retireT exp);
      assert (retire.valid === exp.valid && retire.pc === exp.pc && retire.regWe === exp.regWe
              && (!exp.regWe || (retire.regDst === exp.regDst && retire.regData === exp.regData)))
      else begin
         mismatches++;
         $display("Mismatch in %s: expected pc %h we %b r%0d=%h, actual pc %h we %b r%0d=%h",
                  name, exp.pc, exp.regWe, exp.regDst, exp.regData,
                  retire.pc, retire.regWe, retire.regDst, retire.regData);
      end
   endtask

   task automatic runProgram(input string name);
      procPkg::retireT exp;
      int              cycles;
      cycles = 0;
      @(negedge clk); // retire settled mid-cycle
      while (halt !== 1'b1 && !refStopped && cycles < timeoutCycles) begin
         modelStep(exp);
         checkRetire(name, exp);
         assert (err === 1'b0) else begin
            mismatches++;
            $display("Mismatch in %s: err expected 0, actual %b", name, err);
         end
         cycles++;
         @(negedge clk);
      end
      if (cycles >= timeoutCycles) begin
         failures++;
         $display("%s timed out, no halt within %0d cycles", name, timeoutCycles);
      end else begin
         assert (halt === 1'b1 && refStopped) else begin
            failures++;
            $display("%s: halt did not rise on the edge after the stopping instruction", name);
         end
         assert (err === refIllegal) else begin
            mismatches++;
            $display("Mismatch in %s: err expected %b, actual %b", name, refIllegal, err);
         end
      end
   endtask

   task automatic arithmetic();
      progLen = 0;
      setConst(3'd1, 16'($urandom));
      setConst(3'd2, 16'($urandom));
      emit(rWord(3'd1, 3'd2, 3'd3, procPkg::funcAdd));
      emit(rWord(3'd1, 3'd2, 3'd4, procPkg::funcSub));
      emit(rWord(3'd2, 3'd1, 3'd5, procPkg::funcXor));
      emit(rWord(3'd1, 3'd2, 3'd6, procPkg::funcAnd));
      emit(iWord(procPkg::opAddi, 3'd1, 3'd7, 5'($urandom)));
      emit(iWord(procPkg::opSubi, 3'd2, 3'd0, 5'($urandom)));
      emit(iWord(procPkg::opAndni, 3'd1, 3'd3, 5'($urandom)));
      emit(bWord(procPkg::opLbi, 3'd4, 8'($urandom))); // lone LBI, sign extended
      emit(rWord(3'd3, 3'd0, 3'd1, procPkg::funcSub)); // chains earlier results
      emit(haltWord);
      resetAndLoad();
      runProgram("arithmetic");
   endtask

   task automatic memoryAccess();
      progLen = 0;
      emit(bWord(procPkg::opLbi, 3'd1, 8'h20)); // base address
      for (int r = 2; r < 6; r++) begin
         setConst(3'(r), 16'($urandom));
      end
      for (int k = 0; k < 4; k++) begin
         emit(iWord(procPkg::opSt, 3'd1, 3'(k + 2), 5'(2 * k - 2))); // offsets -2 to 4
      end
      for (int k = 0; k < 4; k++) begin
         emit(iWord(procPkg::opLd, 3'd1, 3'(k + 6), 5'(2 * k - 2))); // into r6, r7, r0, r1
      end
      emit(iWord(procPkg::opLd, 3'd2, 3'd3, 5'd8)); // random address
      emit(haltWord);
      resetAndLoad();
      runProgram("memory");
   endtask

   task automatic branches();
      progLen = 0;
      emit(bWord(procPkg::opLbi, 3'd1, 8'd0));
      emit(bWord(procPkg::opLbi, 3'd2, 8'(($urandom % 255) + 1))); // never zero
      emit(bWord(procPkg::opBeqz, 3'd1, 8'd2)); // taken
      emit(iWord(procPkg::opAddi, 3'd3, 3'd3, 5'd1));
      emit(bWord(procPkg::opBeqz, 3'd2, 8'd2)); // falls through
      emit(iWord(procPkg::opAddi, 3'd3, 3'd3, 5'd2));
      emit(bWord(procPkg::opBnez, 3'd2, 8'd2)); // taken
      emit(iWord(procPkg::opAddi, 3'd3, 3'd3, 5'd4));
      emit(bWord(procPkg::opBnez, 3'd1, 8'd2)); // falls through
      emit(iWord(procPkg::opAddi, 3'd3, 3'd3, 5'd8));
      emit(bWord(procPkg::opLbi, 3'd4, 8'd3));  // loop count
      emit(iWord(procPkg::opSubi, 3'd4, 3'd4, 5'd1));
      emit(bWord(procPkg::opBnez, 3'd4, 8'hfc)); // back to SUBI
      emit(haltWord);
      resetAndLoad();
      runProgram("branches");
   endtask

   task automatic jumps();
      progLen = 0;
      emit(jWord(procPkg::opJ, 11'd4));   // over two words
      emit(iWord(procPkg::opAddi, 3'd1, 3'd1, 5'd1));
      emit(iWord(procPkg::opAddi, 3'd1, 3'd1, 5'd1));
      emit(jWord(procPkg::opJal, 11'd2)); // r7 gets 8
      emit(iWord(procPkg::opAddi, 3'd2, 3'd2, 5'd1));
      emit(iWord(procPkg::opAddi, 3'd7, 3'd3, 5'd0)); // copy of the link
      emit(jWord(procPkg::opJ, 11'd2));
      emit(haltWord);
      emit(jWord(procPkg::opJ, 11'h7fc)); // backward onto HALT
      resetAndLoad();
      runProgram("jumps");
   endtask

   task automatic haltAndIllegal();
      progLen = 0;
      emit(bWord(procPkg::opLbi, 3'd1, 8'($urandom)));
      emit(haltWord);
      emit(iWord(procPkg::opAddi, 3'd1, 3'd1, 5'd1)); // must never retire
      resetAndLoad();
      runProgram("haltAndIllegal");
      for (int k = 0; k < 3; k++) begin
         @(negedge clk);
         assert (halt === 1'b1 && err === 1'b0 && retire.valid === 1'b0) else begin
            failures++;
            $display("haltAndIllegal: machine did not stay stopped after HALT");
         end
      end
      progLen = 0;
      emit(bWord(procPkg::opLbi, 3'd2, 8'($urandom)));
      emit(illegalWord);
      emit(iWord(procPkg::opAddi, 3'd2, 3'd2, 5'd1));
      resetAndLoad();
      runProgram("haltAndIllegal"); // err expected with halt
   endtask

   initial begin
      void'($urandom(32'h4080)); // fixed seed
      arithmetic();
      memoryAccess();
      branches();
      jumps();
      haltAndIllegal();
      $display("error counts: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* filelist.f */
logic/procPkg.sv
logic/fetch.sv
logic/regFile.sv
logic/decode.sv
logic/execute.sv
logic/memory.sv
logic/writeback.sv
logic/proc.sv
verification/proc_sva.sv
verification/procTb.sv
